// File: dbg_pkg.sv
package dbg_pkg;

  // Datapath widths of the probed pipeline
  localparam int BYTE_W    = 8;   // One frame byte
  localparam int WORD_W    = 32;  // ALU and register word
  localparam int PC_W      = 8;   // Program counter fits one byte
  localparam int REG_IDX_W = 5;   // Register file index

  // Frame layout with one byte per narrow field
  localparam int FRAME_BYTES = 56;

  localparam int IF_BASE  = 0;   // PCs and instruction
  localparam int ID_BASE  = 6;   // Operands, immediate and decode control
  localparam int EX_BASE  = 29;  // ALU result and execute control
  localparam int MEM_BASE = 45;  // Memory stage outputs up to byte 55

  // Read pointer into the frame
  typedef logic [$clog2(FRAME_BYTES)-1:0] frame_idx_t;

  // Whole frame with element 0 read out first
  typedef logic [FRAME_BYTES-1:0][BYTE_W-1:0] frame_t;

  // A probe word seen either whole or as bytes
  typedef union packed
  {
    logic [WORD_W-1:0]                    word;   // Full value
    logic [WORD_W/BYTE_W-1:0][BYTE_W-1:0] bytes;  // Element 3 is the MSB
  } word_bytes_u;

endpackage

// File: pipe_probe_if.sv
`timescale 1ns/10ps

interface pipe_probe_if;
  import dbg_pkg::*;

  logic [PC_W-1:0]      current_pc, pc_if;                     // Fetch
  logic [WORD_W-1:0]    instr_if;                              // Fetched instruction
  logic [WORD_W-1:0]    data_a_id, data_b_id, sign_ext_id;     // Decode operands
  logic [PC_W-1:0]      jump_dest_id;                          // Branch target in ID
  logic [REG_IDX_W-1:0] reg_dest_r_id, reg_dest_l_id;          // R and I type dest
  logic                 reg_dst_id, alu_src_id, mem_to_reg_id; // Decode control
  logic                 reg_write_id, mem_read_id, mem_write_id;
  logic                 branch_id;
  logic [1:0]           alu_op_id;                             // ALUOp pair
  logic [WORD_W-1:0]    result_ie, reg2_ie;                    // EX/MEM words
  logic [PC_W-1:0]      jump_dest_ie;
  logic                 zero_ie;                               // ALU zero flag
  logic [REG_IDX_W-1:0] reg_dest_ie;
  logic                 mem_to_reg_ie, reg_write_ie, mem_read_ie;
  logic                 mem_write_ie, branch_ie;
  logic [WORD_W-1:0]    mem_data_mem, alu_result_mem;          // MEM/WB words
  logic [REG_IDX_W-1:0] reg_dest_mem;
  logic                 mem_to_reg_mem, reg_write_mem;

  modport source (output current_pc, pc_if, instr_if, data_a_id, data_b_id, sign_ext_id,
                  jump_dest_id, reg_dest_r_id, reg_dest_l_id, reg_dst_id, alu_src_id,
                  mem_to_reg_id, reg_write_id, mem_read_id, mem_write_id, branch_id,
                  alu_op_id, result_ie, reg2_ie, jump_dest_ie, zero_ie, reg_dest_ie,
                  mem_to_reg_ie, reg_write_ie, mem_read_ie, mem_write_ie, branch_ie,
                  mem_data_mem, alu_result_mem, reg_dest_mem, mem_to_reg_mem,
                  reg_write_mem);

  modport sink (input current_pc, pc_if, instr_if, data_a_id, data_b_id, sign_ext_id,
                jump_dest_id, reg_dest_r_id, reg_dest_l_id, reg_dst_id, alu_src_id,
                mem_to_reg_id, reg_write_id, mem_read_id, mem_write_id, branch_id,
                alu_op_id, result_ie, reg2_ie, jump_dest_ie, zero_ie, reg_dest_ie,
                mem_to_reg_ie, reg_write_ie, mem_read_ie, mem_write_ie, branch_ie,
                mem_data_mem, alu_result_mem, reg_dest_mem, mem_to_reg_mem,
                reg_write_mem);

endinterface

// File: snapshot_capture.sv
`timescale 1ns/10ps

module snapshot_capture
(
  input  logic              clk,
  input  logic              rst_n,
  pipe_probe_if.sink        probes,
  input  logic              take,   // Load strobe from readout
  output dbg_pkg::frame_t   frame   // Held snapshot
);
  import dbg_pkg::*;

  localparam int WORD_BYTES = WORD_W / BYTE_W;

  frame_t packed_frame;  // Live probes in frame order

  // Drops one word into the frame with its MSB at the lowest offset
  function automatic frame_t put_word(input frame_t f, input int base,
                                      input logic [WORD_W-1:0] value);
    word_bytes_u w;
    w.word = value;
    for (int i = 0; i < WORD_BYTES; i++)
    begin
      f[base + i] = w.bytes[WORD_BYTES - 1 - i];  // bytes[3] first
    end
    return f;
  endfunction

  always_comb
  begin
    packed_frame = '0;  // Cleared first since put_word reads it back

    // Fetch
    packed_frame[IF_BASE]     = BYTE_W'(probes.current_pc);  // Next PC
    packed_frame[IF_BASE + 1] = BYTE_W'(probes.pc_if);       // PC+1 latched in IF/ID
    packed_frame = put_word(packed_frame, IF_BASE + 2, probes.instr_if);

    // Decode words, then index fields and control
    packed_frame = put_word(packed_frame, ID_BASE, probes.data_a_id);
    packed_frame = put_word(packed_frame, ID_BASE + 4, probes.data_b_id);
    packed_frame = put_word(packed_frame, ID_BASE + 8, probes.sign_ext_id);
    packed_frame[ID_BASE + 12] = BYTE_W'(probes.jump_dest_id);
    packed_frame[ID_BASE + 13] = BYTE_W'(probes.reg_dest_r_id);  // rd
    packed_frame[ID_BASE + 14] = BYTE_W'(probes.reg_dest_l_id);  // rt
    packed_frame[ID_BASE + 15] = BYTE_W'(probes.reg_dst_id);
    packed_frame[ID_BASE + 16] = BYTE_W'(probes.alu_src_id);
    packed_frame[ID_BASE + 17] = BYTE_W'(probes.mem_to_reg_id);
    packed_frame[ID_BASE + 18] = BYTE_W'(probes.reg_write_id);
    packed_frame[ID_BASE + 19] = BYTE_W'(probes.mem_read_id);
    packed_frame[ID_BASE + 20] = BYTE_W'(probes.mem_write_id);
    packed_frame[ID_BASE + 21] = BYTE_W'(probes.branch_id);
    packed_frame[ID_BASE + 22] = BYTE_W'(probes.alu_op_id);  // Two bits used

    // Execute stage as seen in EX/MEM
    packed_frame = put_word(packed_frame, EX_BASE, probes.result_ie);
    packed_frame = put_word(packed_frame, EX_BASE + 4, probes.reg2_ie);  // Store data
    packed_frame[EX_BASE + 8]  = BYTE_W'(probes.jump_dest_ie);
    packed_frame[EX_BASE + 9]  = BYTE_W'(probes.zero_ie);
    packed_frame[EX_BASE + 10] = BYTE_W'(probes.reg_dest_ie);
    packed_frame[EX_BASE + 11] = BYTE_W'(probes.mem_to_reg_ie);
    packed_frame[EX_BASE + 12] = BYTE_W'(probes.reg_write_ie);
    packed_frame[EX_BASE + 13] = BYTE_W'(probes.mem_read_ie);
    packed_frame[EX_BASE + 14] = BYTE_W'(probes.mem_write_ie);
    packed_frame[EX_BASE + 15] = BYTE_W'(probes.branch_ie);

    // Memory stage as seen in MEM/WB
    packed_frame = put_word(packed_frame, MEM_BASE, probes.mem_data_mem);
    packed_frame = put_word(packed_frame, MEM_BASE + 4, probes.alu_result_mem);
    packed_frame[MEM_BASE + 8]  = BYTE_W'(probes.reg_dest_mem);
    packed_frame[MEM_BASE + 9]  = BYTE_W'(probes.mem_to_reg_mem);
    packed_frame[MEM_BASE + 10] = BYTE_W'(probes.reg_write_mem);  // Byte 55
  end

  // Snapshot register loads only when readout grants a capture
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      frame <= '0;
    end
    else if (take)
    begin
      frame <= packed_frame;  // Whole frame in one edge
    end
  end

endmodule

// File: byte_readout.sv
`timescale 1ns/10ps

module byte_readout
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      capture,      // Host snapshot request
  input  logic                      advance,      // Host byte pop
  input  dbg_pkg::frame_t           frame,
  output logic                      take,         // Load pulse to capture logic
  output logic [dbg_pkg::BYTE_W-1:0] read_data,
  output logic                      frame_full,
  output logic                      frame_empty
);
  import dbg_pkg::*;

  localparam frame_idx_t LAST_IDX = frame_idx_t'(FRAME_BYTES - 1);

  logic       held;     // A frame is waiting to be read
  frame_idx_t rd_idx;   // Byte currently on read_data
  logic       adv_ok;   // Accepted advance

  assign take   = capture && !held;   // Held frame is kept under back-pressure
  assign adv_ok = advance && held;    // Ignored while empty

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      held   <= 1'b0;
      rd_idx <= '0;
    end
    else if (take)
    begin
      held   <= 1'b1;
      rd_idx <= '0;  // Start readout at byte 0
    end
    else if (adv_ok)
    begin
      if (rd_idx == LAST_IDX)
      begin
        held   <= 1'b0;  // Last byte consumed
        rd_idx <= '0;
      end
      else
      begin
        rd_idx <= rd_idx + frame_idx_t'(1);
      end
    end
  end

  assign read_data   = frame[rd_idx];             // Byte 0 shows while empty
  assign frame_full  = held && (rd_idx == '0);    // Held and untouched
  assign frame_empty = !held;

endmodule

// File: pipe_snapshot_top.sv
`timescale 1ns/10ps

module pipe_snapshot_top
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            capture,
  input  logic                            advance,
  // Fetch
  input  logic [dbg_pkg::PC_W-1:0]        current_pc,
  input  logic [dbg_pkg::PC_W-1:0]        pc_if,
  input  logic [dbg_pkg::WORD_W-1:0]      instr_if,
  // Decode
  input  logic [dbg_pkg::WORD_W-1:0]      data_a_id,
  input  logic [dbg_pkg::WORD_W-1:0]      data_b_id,
  input  logic [dbg_pkg::WORD_W-1:0]      sign_ext_id,
  input  logic [dbg_pkg::PC_W-1:0]        jump_dest_id,
  input  logic [dbg_pkg::REG_IDX_W-1:0]   reg_dest_r_id,
  input  logic [dbg_pkg::REG_IDX_W-1:0]   reg_dest_l_id,
  input  logic                            reg_dst_id,
  input  logic                            alu_src_id,
  input  logic                            mem_to_reg_id,
  input  logic                            reg_write_id,
  input  logic                            mem_read_id,
  input  logic                            mem_write_id,
  input  logic                            branch_id,
  input  logic [1:0]                      alu_op_id,
  // Execute
  input  logic [dbg_pkg::WORD_W-1:0]      result_ie,
  input  logic [dbg_pkg::WORD_W-1:0]      reg2_ie,
  input  logic [dbg_pkg::PC_W-1:0]        jump_dest_ie,
  input  logic                            zero_ie,
  input  logic [dbg_pkg::REG_IDX_W-1:0]   reg_dest_ie,
  input  logic                            mem_to_reg_ie,
  input  logic                            reg_write_ie,
  input  logic                            mem_read_ie,
  input  logic                            mem_write_ie,
  input  logic                            branch_ie,
  // Memory
  input  logic [dbg_pkg::WORD_W-1:0]      mem_data_mem,
  input  logic [dbg_pkg::WORD_W-1:0]      alu_result_mem,
  input  logic [dbg_pkg::REG_IDX_W-1:0]   reg_dest_mem,
  input  logic                            mem_to_reg_mem,
  input  logic                            reg_write_mem,
  // Host side
  output logic [dbg_pkg::BYTE_W-1:0]      read_data,
  output logic                            frame_full,
  output logic                            frame_empty
);
  import dbg_pkg::*;

  logic   take;   // Capture granted this cycle
  frame_t frame;  // Held snapshot to the serializer

  pipe_probe_if probes();

  // Probe ports onto the bundle
  assign probes.current_pc     = current_pc;
  assign probes.pc_if          = pc_if;
  assign probes.instr_if       = instr_if;
  assign probes.data_a_id      = data_a_id;
  assign probes.data_b_id      = data_b_id;
  assign probes.sign_ext_id    = sign_ext_id;
  assign probes.jump_dest_id   = jump_dest_id;
  assign probes.reg_dest_r_id  = reg_dest_r_id;
  assign probes.reg_dest_l_id  = reg_dest_l_id;
  assign probes.reg_dst_id     = reg_dst_id;
  assign probes.alu_src_id     = alu_src_id;
  assign probes.mem_to_reg_id  = mem_to_reg_id;
  assign probes.reg_write_id   = reg_write_id;
  assign probes.mem_read_id    = mem_read_id;
  assign probes.mem_write_id   = mem_write_id;
  assign probes.branch_id      = branch_id;
  assign probes.alu_op_id      = alu_op_id;
  assign probes.result_ie      = result_ie;
  assign probes.reg2_ie        = reg2_ie;
  assign probes.jump_dest_ie   = jump_dest_ie;
  assign probes.zero_ie        = zero_ie;
  assign probes.reg_dest_ie    = reg_dest_ie;
  assign probes.mem_to_reg_ie  = mem_to_reg_ie;
  assign probes.reg_write_ie   = reg_write_ie;
  assign probes.mem_read_ie    = mem_read_ie;
  assign probes.mem_write_ie   = mem_write_ie;
  assign probes.branch_ie      = branch_ie;
  assign probes.mem_data_mem   = mem_data_mem;
  assign probes.alu_result_mem = alu_result_mem;
  assign probes.reg_dest_mem   = reg_dest_mem;
  assign probes.mem_to_reg_mem = mem_to_reg_mem;
  assign probes.reg_write_mem  = reg_write_mem;

  snapshot_capture snapshot_capture_inst
  (
    .clk    (clk),
    .rst_n  (rst_n),
    .probes (probes.sink),
    .take   (take),
    .frame  (frame)
  );

  byte_readout byte_readout_inst
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .capture     (capture),
    .advance     (advance),
    .frame       (frame),
    .take        (take),
    .read_data   (read_data),
    .frame_full  (frame_full),
    .frame_empty (frame_empty)
  );

endmodule

// File: snapshot_checker.sv
`timescale 1ns/10ps

module snapshot_checker
(
  input  logic clk, rst_n, capture, advance,
  input  logic [dbg_pkg::PC_W-1:0]      current_pc, pc_if, jump_dest_id, jump_dest_ie,
  input  logic [dbg_pkg::WORD_W-1:0]    instr_if, data_a_id, data_b_id, sign_ext_id,
                                        result_ie, reg2_ie, mem_data_mem, alu_result_mem,
  input  logic [dbg_pkg::REG_IDX_W-1:0] reg_dest_r_id, reg_dest_l_id, reg_dest_ie,
                                        reg_dest_mem,
  input  logic reg_dst_id, alu_src_id, mem_to_reg_id, reg_write_id, mem_read_id,
               mem_write_id, branch_id, zero_ie, mem_to_reg_ie, reg_write_ie,
               mem_read_ie, mem_write_ie, branch_ie, mem_to_reg_mem, reg_write_mem,
  input  logic [1:0]                    alu_op_id,
  input  logic [dbg_pkg::BYTE_W-1:0]    read_data,
  input  logic                          frame_full, frame_empty,
  input  int                            test_id,
  output int                            error_count, check_count, test_count
);
  import dbg_pkg::*;

  logic [FRAME_BYTES*BYTE_W-1:0] stream;                  // Frame as one byte stream
  logic [BYTE_W-1:0]             exp_frame [FRAME_BYTES];  // Predicted bytes
  logic                          held;
  int                            idx, prev_id, errs_at_start;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    check_count++;
    if (got !== want)
    begin
      error_count++;
      $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, want, got);
    end
  endtask

  // Words go MSB first and each narrow field is zero-extended into its own byte
  task automatic take_snapshot();
    stream = {current_pc, pc_if, instr_if,                          // Byte 0
              data_a_id, data_b_id, sign_ext_id, jump_dest_id,      // Byte 6
              BYTE_W'(reg_dest_r_id), BYTE_W'(reg_dest_l_id), BYTE_W'(reg_dst_id),
              BYTE_W'(alu_src_id), BYTE_W'(mem_to_reg_id), BYTE_W'(reg_write_id),
              BYTE_W'(mem_read_id), BYTE_W'(mem_write_id), BYTE_W'(branch_id),
              BYTE_W'(alu_op_id),
              result_ie, reg2_ie, jump_dest_ie, BYTE_W'(zero_ie),   // Byte 29
              BYTE_W'(reg_dest_ie), BYTE_W'(mem_to_reg_ie), BYTE_W'(reg_write_ie),
              BYTE_W'(mem_read_ie), BYTE_W'(mem_write_ie), BYTE_W'(branch_ie),
              mem_data_mem, alu_result_mem, BYTE_W'(reg_dest_mem),  // Byte 45
              BYTE_W'(mem_to_reg_mem), BYTE_W'(reg_write_mem)};
    for (int k = 0; k < FRAME_BYTES; k++)
    begin
      exp_frame[k] = stream[(FRAME_BYTES-1-k)*BYTE_W +: BYTE_W];  // Byte 0 at the top
    end
  endtask

  initial
  begin
    error_count   = 0;
    check_count   = 0;
    test_count    = 0;
    prev_id       = 0;
    errs_at_start = 0;
  end

  always @(posedge clk)
  begin
    if (test_id != prev_id)
    begin
      if (prev_id != 0)
      begin
        test_count++;
        $display("Test %0d done: %0d errors", prev_id, error_count - errs_at_start);
      end
      errs_at_start = error_count;
      prev_id       = test_id;
    end
    if (!rst_n)
    begin
      held = 1'b0;
      idx  = 0;
      for (int k = 0; k < FRAME_BYTES; k++)
      begin
        exp_frame[k] = '0;  // Zero frame after reset
      end
    end
    else
    begin
      check_value("frame_empty", 32'(frame_empty), 32'(!held));
      check_value("frame_full", 32'(frame_full), 32'(held && idx == 0));
      check_value("read_data", 32'(read_data), 32'(exp_frame[idx]));
      if (capture && !held)
      begin
        take_snapshot();  // Capture wins over a simultaneous advance
        held = 1'b1;
        idx  = 0;
      end
      else if (advance && held)
      begin
        idx  = (idx == FRAME_BYTES - 1) ? 0 : idx + 1;
        held = (idx != 0);  // Wrap after byte 55 empties the buffer
      end
    end
  end

endmodule

// File: tb_pipe_snapshot.sv
`timescale 1ns/10ps

module tb_pipe_snapshot;
  import dbg_pkg::*;

  typedef enum logic [1:0] {IDLE, CAP, ADV, BOTH} op_e;
  typedef enum logic [1:0] {W_NONE, W_FULL, W_EMPTY} wait_e;
  typedef struct packed {op_e op; int count; wait_e wait_on; int test;} row_t;

  localparam int TIMEOUT    = 20;   // Cycles allowed for a status change
  localparam int PROBE_BITS = 325;  // All probe inputs back to back
  localparam logic [15:0] SEED = 16'd58;
  localparam int ROWS = 9;
  localparam row_t STIM [ROWS] = '{
    '{IDLE, 2, W_NONE, 1},   // Status out of reset
    '{CAP, 1, W_FULL, 2},    // First capture
    '{ADV, 20, W_NONE, 3},   // Bytes 1 to 20
    '{CAP, 1, W_NONE, 4},    // Refused while the frame is held
    '{ADV, 35, W_NONE, 4},   // Bytes 21 to 55 of the first frame
    '{ADV, 1, W_EMPTY, 5},   // Past the last byte
    '{ADV, 3, W_NONE, 5},    // Ignored while empty
    '{BOTH, 1, W_FULL, 5},   // Counts as a capture only
    '{IDLE, 2, W_NONE, 5}
  };

  logic                  clk, rst_n, capture, advance;
  logic [PC_W-1:0]       current_pc, pc_if, jump_dest_id, jump_dest_ie;
  logic [WORD_W-1:0]     instr_if, data_a_id, data_b_id, sign_ext_id, result_ie, reg2_ie;
  logic [WORD_W-1:0]     mem_data_mem, alu_result_mem;
  logic [REG_IDX_W-1:0]  reg_dest_r_id, reg_dest_l_id, reg_dest_ie, reg_dest_mem;
  logic                  reg_dst_id, alu_src_id, mem_to_reg_id, reg_write_id, mem_read_id;
  logic                  mem_write_id, branch_id, zero_ie, mem_to_reg_ie, reg_write_ie;
  logic                  mem_read_ie, mem_write_ie, branch_ie, mem_to_reg_mem, reg_write_mem;
  logic [1:0]            alu_op_id;
  logic [BYTE_W-1:0]     read_data;
  logic                  frame_full, frame_empty;
  logic [PROBE_BITS-1:0] probe_bus;  // One random draw spread over the probes
  logic [15:0]           lfsr;
  logic                  timed_out;
  int                    test_id, error_count, check_count, test_count;

  assign {current_pc, pc_if, instr_if, data_a_id, data_b_id, sign_ext_id, jump_dest_id,
          reg_dest_r_id, reg_dest_l_id, reg_dst_id, alu_src_id, mem_to_reg_id, reg_write_id,
          mem_read_id, mem_write_id, branch_id, alu_op_id, result_ie, reg2_ie, jump_dest_ie,
          zero_ie, reg_dest_ie, mem_to_reg_ie, reg_write_ie, mem_read_ie, mem_write_ie,
          branch_ie, mem_data_mem, alu_result_mem, reg_dest_mem, mem_to_reg_mem,
          reg_write_mem} = probe_bus;

  pipe_snapshot_top pipe_snapshot_top_inst (.*);
  snapshot_checker  snapshot_checker_inst (.*);

  // Fibonacci LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic redraw_probes();
    logic [PROBE_BITS-1:0] v;
    v = '0;
    for (int i = 0; i < PROBE_BITS; i++)
    begin
      v    = {v[PROBE_BITS-2:0], lfsr[15]};  // One step per bit
      lfsr = lfsr_step(lfsr);
    end
    probe_bus <= v;
  endtask

  task automatic wait_status(input wait_e w);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && !timed_out)
    begin
      @(posedge clk);
      done = (w == W_FULL) ? (frame_full === 1'b1) : (frame_empty === 1'b1);
      cycles++;
      if (!done && cycles >= TIMEOUT)
      begin
        $display("Timeout: frame status never reached %s after %0d cycles", w.name(), TIMEOUT);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    for (int n = 0; n < r.count; n++)
    begin
      @(posedge clk);
      if (r.op == CAP || r.op == BOTH)
      begin
        redraw_probes();  // New probe values with every capture
      end
      capture <= (r.op == CAP || r.op == BOTH);
      advance <= (r.op == ADV || r.op == BOTH);
      test_id <= r.test;
    end
    @(posedge clk);
    capture <= 1'b0;
    advance <= 1'b0;
    if (r.wait_on != W_NONE)
    begin
      wait_status(r.wait_on);
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial
  begin
    rst_n     = 1'b0;
    capture   = 1'b0;
    advance   = 1'b0;
    probe_bus = '0;
    lfsr      = SEED;
    test_id   = 0;
    timed_out = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < ROWS; r++)
    begin
      if (!timed_out)
      begin
        apply_row(STIM[r]);
      end
    end
    @(posedge clk);
    test_id <= 0;  // Closes the last test
    repeat (2) @(posedge clk);
    @(negedge clk);  // Checker is done with the last edge
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (timed_out || error_count != 0)
    begin
      $display("FAIL: see errors above");
    end
    else
    begin
      $display("PASS: all tests");
    end
    $finish;
  end

endmodule

// File: list.f
dbg_pkg.sv
pipe_probe_if.sv
snapshot_capture.sv
byte_readout.sv
pipe_snapshot_top.sv
snapshot_checker.sv
tb_pipe_snapshot.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -j 0 \
  --top-module tb_pipe_snapshot -f list.f -o tb_pipe_snapshot_sim

out=$(./obj_dir/tb_pipe_snapshot_sim)
echo "$out"
echo "$out" | grep -qx "PASS: all tests"
